/* list.f */
source/mb_pkg.sv
source/mb_encode_ctrl.sv
source/mb_predict_quant.sv
source/mb_boundary.sv
source/mb_level_packer.sv
source/mb_encode_top.sv
tb/mb_encode_props.sv
tb/tb_mb_encode.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log

verilator --binary --assert --top-module tb_mb_encode -f list.f -o sim_mb_encode \
    && ./obj_dir/sim_mb_encode | tee sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    || { echo "run_sim: simulation failed"; exit 1; }

echo "run_sim: simulation passed"

/* source/mb_boundary.sv */
`timescale 1ns/1ps

module mb_boundary import mb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 frame_init,
    input  logic                 mb_done,
    input  logic [COORD_W-1:0]   x,
    input  logic [MB_DATA_W-1:0] recon,
    output logic [EDGE_W-1:0]    top_pix,
    output logic [EDGE_W-1:0]    left_pix
);

    logic [EDGE_W-1:0]   top_buf [MAX_MB_W];
    logic [MAX_MB_W-1:0] top_valid;
    logic [EDGE_W-1:0]   left_col;
    logic [EDGE_W-1:0]   right_col;

    // Right column of the block, row 0 in the low byte
    always_comb begin
        for (int r = 0; r < MB_SIDE; r++) begin
            right_col[r*PIX_W +: PIX_W] = recon[(r*MB_SIDE + MB_SIDE - 1)*PIX_W +: PIX_W];
        end
    end

    // --------------------
    // Line buffer
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_valid <= '0;
        end else if (frame_init) begin
            top_valid <= '0;
        end else if (mb_done) begin
            top_valid[x] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mb_done) begin
            // Bottom row feeds the next macroblock row
            top_buf[x] <= recon[MB_DATA_W-1 -: EDGE_W];
            left_col   <= right_col;
        end
    end

    assign top_pix  = top_valid[x] ? top_buf[x] : {MB_SIDE{TOP_DEFAULT}};
    assign left_pix = (x == '0) ? {MB_SIDE{LEFT_DEFAULT}} : left_col;

endmodule

/* source/mb_encode_ctrl.sv */
`timescale 1ns/1ps

module mb_encode_ctrl import mb_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [COORD_W:0]   mb_w,
    input  logic [COORD_W:0]   mb_h,
    input  logic               pix_empty,
    input  logic               fifo_full,
    input  logic               mb_done,
    output logic               pix_rd,
    output logic               mb_start,
    output logic               frame_init,
    output logic [COORD_W-1:0] x,
    output logic [COORD_W-1:0] y,
    output logic               done
);

    enc_state_t         state;
    enc_state_t         state_next;
    logic [COORD_W-1:0] w_last;
    logic [COORD_W-1:0] h_last;
    logic [1:0]         drain_cnt;
    logic               drained;
    logic               last_mb;

    assign drained = (drain_cnt == 2'(WORDS_PER_MB));
    assign last_mb = (x == w_last) && (y == h_last);

    // Strobes decoded from state
    assign pix_rd     = (state == ST_RDEN) && !pix_empty;
    assign mb_start   = (state == ST_DSTART);
    assign frame_init = (state == ST_INIT);
    assign done       = (state == ST_DONE);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:    if (start) state_next = ST_INIT;
            ST_INIT:    state_next = ST_RDEN;
            ST_RDEN:    if (!pix_empty) state_next = ST_DSTART;
            ST_DSTART:  state_next = ST_WAIT;
            ST_WAIT:    if (mb_done) state_next = ST_FULL;
            ST_FULL: begin
                // Let the packer finish, then wait for room for the next burst
                if (drained && !fifo_full) begin
                    state_next = last_mb ? ST_DONE : ST_ADVANCE;
                end
            end
            ST_ADVANCE: state_next = ST_RDEN;
            ST_DONE:    state_next = ST_IDLE;
            default:    state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Cycles since mb_done, saturating at the burst length
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_cnt <= '0;
        end else if (mb_done) begin
            drain_cnt <= '0;
        end else if (state == ST_FULL && !drained) begin
            drain_cnt <= drain_cnt + 2'd1;
        end
    end

    // --------------------
    // Raster position
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x      <= '0;
            y      <= '0;
            w_last <= '0;
            h_last <= '0;
        end else if (state == ST_INIT) begin
            x      <= '0;
            y      <= '0;
            w_last <= COORD_W'(mb_w - 1'b1);
            h_last <= COORD_W'(mb_h - 1'b1);
        end else if (state == ST_ADVANCE) begin
            if (x == w_last) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

/* source/mb_encode_top.sv */
`timescale 1ns/1ps

module mb_encode_top import mb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [COORD_W:0]     mb_w,
    input  logic [COORD_W:0]     mb_h,
    input  logic [2:0]           q_shift,
    input  logic                 pix_empty,
    output logic                 pix_rd,
    input  logic [MB_DATA_W-1:0] pix_data,
    input  logic                 fifo_full,
    output logic                 out_wr,
    output logic [OUT_W-1:0]     out_data,
    output logic                 done
);

    logic                 mb_start;
    logic                 mb_done;
    logic                 frame_init;
    logic [COORD_W-1:0]   x;
    logic [COORD_W-1:0]   y;
    logic [EDGE_W-1:0]    top_pix;
    logic [EDGE_W-1:0]    left_pix;
    logic [MB_DATA_W-1:0] levels;
    logic [MB_DATA_W-1:0] recon;
    logic [PIX_W-1:0]     pred;
    logic                 skipped;
    logic [NZ_W-1:0]      nz;

    mb_encode_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .mb_w(mb_w), .mb_h(mb_h),
        .pix_empty(pix_empty), .fifo_full(fifo_full), .mb_done(mb_done),
        .pix_rd(pix_rd), .mb_start(mb_start), .frame_init(frame_init),
        .x(x), .y(y), .done(done)
    );

    mb_predict_quant u_predict_quant (
        .clk(clk), .rst_n(rst_n), .mb_start(mb_start), .pix_data(pix_data),
        .top_pix(top_pix), .left_pix(left_pix), .q_shift(q_shift),
        .mb_done(mb_done), .levels(levels), .recon(recon), .pred(pred),
        .skipped(skipped), .nz(nz)
    );

    mb_boundary u_boundary (
        .clk(clk), .rst_n(rst_n), .frame_init(frame_init), .mb_done(mb_done),
        .x(x), .recon(recon), .top_pix(top_pix), .left_pix(left_pix)
    );

    mb_level_packer u_level_packer (
        .clk(clk), .rst_n(rst_n), .mb_done(mb_done), .x(x), .y(y),
        .levels(levels), .pred(pred), .skipped(skipped), .nz(nz),
        .out_wr(out_wr), .out_data(out_data)
    );

endmodule

/* source/mb_level_packer.sv */
`timescale 1ns/1ps

module mb_level_packer import mb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mb_done,
    input  logic [COORD_W-1:0]   x,
    input  logic [COORD_W-1:0]   y,
    input  logic [MB_DATA_W-1:0] levels,
    input  logic [PIX_W-1:0]     pred,
    input  logic                 skipped,
    input  logic [NZ_W-1:0]      nz,
    output logic                 out_wr,
    output logic [OUT_W-1:0]     out_data
);

    logic [1:0]           word_cnt;
    logic [COORD_W-1:0]   x_c;
    logic [COORD_W-1:0]   y_c;
    logic [MB_DATA_W-1:0] levels_c;
    logic [PIX_W-1:0]     pred_c;
    logic                 skipped_c;
    logic [NZ_W-1:0]      nz_c;

    always_ff @(posedge clk) begin
        if (mb_done) begin
            x_c       <= x;
            y_c       <= y;
            levels_c  <= levels;
            pred_c    <= pred;
            skipped_c <= skipped;
            nz_c      <= nz;
        end
    end

    // 1..3 while a burst is running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (mb_done) begin
            word_cnt <= 2'd1;
        end else if (word_cnt == 2'(WORDS_PER_MB)) begin
            word_cnt <= '0;
        end else if (word_cnt != '0) begin
            word_cnt <= word_cnt + 2'd1;
        end
    end

    assign out_wr = (word_cnt != '0);

    always_comb begin
        case (word_cnt)
            2'd1:    out_data = OUT_W'({pred_c, nz_c, skipped_c, y_c, x_c});
            2'd2:    out_data = levels_c[OUT_W-1:0];
            2'd3:    out_data = levels_c[MB_DATA_W-1:OUT_W];
            default: out_data = '0;
        endcase
    end

endmodule

/* source/mb_pkg.sv */
package mb_pkg;

    // --------------------
    // Macroblock geometry
    // --------------------
    localparam int MB_SIDE   = 4;
    localparam int MB_PIX    = 16;
    localparam int PIX_W     = 8;
    localparam int MB_DATA_W = 128;
    localparam int EDGE_W    = MB_SIDE * PIX_W;

    // Frame limits
    localparam int MAX_MB_W  = 16;
    localparam int COORD_W   = 4;

    // Output stream
    localparam int OUT_W        = 64;
    localparam int WORDS_PER_MB = 3;
    localparam int NZ_W         = 5;

    // Prediction edges before any neighbor exists
    localparam logic [PIX_W-1:0] TOP_DEFAULT  = 8'd127;
    localparam logic [PIX_W-1:0] LEFT_DEFAULT = 8'd129;

    // --------------------
    // Frame controller
    // --------------------
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT,
        ST_RDEN,
        ST_DSTART,
        ST_WAIT,
        ST_FULL,
        ST_ADVANCE,
        ST_DONE
    } enc_state_t;

endpackage

/* source/mb_predict_quant.sv */
`timescale 1ns/1ps

module mb_predict_quant import mb_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mb_start,
    input  logic [MB_DATA_W-1:0] pix_data,
    input  logic [EDGE_W-1:0]    top_pix,
    input  logic [EDGE_W-1:0]    left_pix,
    input  logic [2:0]           q_shift,
    output logic                 mb_done,
    output logic [MB_DATA_W-1:0] levels,
    output logic [MB_DATA_W-1:0] recon,
    output logic [PIX_W-1:0]     pred,
    output logic                 skipped,
    output logic [NZ_W-1:0]      nz
);

    logic [10:0]          dc_sum;
    logic [MB_DATA_W-1:0] pix_r;
    logic [PIX_W-1:0]     pred_r;
    logic                 s1_valid;

    logic signed [9:0]    res     [MB_PIX];
    logic signed [9:0]    shifted [MB_PIX];
    logic signed [7:0]    lvl     [MB_PIX];
    logic signed [15:0]   scaled  [MB_PIX];
    logic signed [16:0]   rec     [MB_PIX];
    logic [MB_DATA_W-1:0] levels_next;
    logic [MB_DATA_W-1:0] recon_next;
    logic [NZ_W-1:0]      nz_next;

    // --------------------
    // Stage 1: DC predictor
    // --------------------
    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < MB_SIDE; i++) begin
            dc_sum = dc_sum + 11'(top_pix[i*PIX_W +: PIX_W]) + 11'(left_pix[i*PIX_W +: PIX_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (mb_start) begin
            pix_r  <= pix_data;
            pred_r <= PIX_W'(dc_sum >> 3);
        end
    end

    // --------------------
    // Stage 2: quantize and rebuild
    // --------------------
    always_comb begin
        nz_next = '0;
        for (int i = 0; i < MB_PIX; i++) begin
            res[i]     = $signed({2'b00, pix_r[i*PIX_W +: PIX_W]}) - $signed({2'b00, pred_r});
            shifted[i] = res[i] >>> q_shift;
            if (shifted[i] > 10'sd127) begin
                lvl[i] = 8'sd127;
            end else if (shifted[i] < -10'sd128) begin
                lvl[i] = -8'sd128;
            end else begin
                lvl[i] = shifted[i][7:0];
            end
            scaled[i] = 16'(lvl[i]) <<< q_shift;
            rec[i]    = $signed({9'b0, pred_r}) + 17'(scaled[i]);
            // Clamp back into pixel range
            if (rec[i] < 0) begin
                recon_next[i*PIX_W +: PIX_W] = '0;
            end else if (rec[i] > 17'sd255) begin
                recon_next[i*PIX_W +: PIX_W] = 8'hff;
            end else begin
                recon_next[i*PIX_W +: PIX_W] = rec[i][7:0];
            end
            levels_next[i*PIX_W +: PIX_W] = lvl[i];
            if (lvl[i] != 8'sd0) begin
                nz_next = nz_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            levels  <= levels_next;
            recon   <= recon_next;
            pred    <= pred_r;
            nz      <= nz_next;
            skipped <= (nz_next == '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            mb_done  <= 1'b0;
        end else begin
            s1_valid <= mb_start;
            mb_done  <= s1_valid;
        end
    end

endmodule

/* tb/mb_encode_props.sv */
`timescale 1ns/1ps

module mb_encode_props (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic pix_empty,
    input logic pix_rd,
    input logic out_wr,
    input logic done
);

    logic start_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_seen <= 1'b0;
        end else if (start) begin
            start_seen <= 1'b1;
        end
    end

    // Output burst is exactly three words
    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_wr) |-> $past(out_wr, 2) && $past(out_wr, 3) && !$past(out_wr, 4))
        else $error("output write burst was not exactly three words long");

    a_read_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pix_empty |-> !pix_rd)
        else $error("pixel FIFO read while the FIFO was empty");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_read_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        !start_seen |-> !pix_rd)
        else $error("pixel FIFO read before any frame was started");

endmodule

bind mb_encode_top mb_encode_props u_props (
    .clk(clk), .rst_n(rst_n), .start(start), .pix_empty(pix_empty),
    .pix_rd(pix_rd), .out_wr(out_wr), .done(done)
);

/* tb/tb_mb_encode.sv */
`timescale 1ns/1ps

module tb_mb_encode import mb_pkg::*; ();

    // 51 macroblocks at a few hundred cycles each under the worst random stalls
    localparam int CYCLE_LIMIT = 20000;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic [COORD_W:0]     mb_w;
    logic [COORD_W:0]     mb_h;
    logic [2:0]           q_shift;
    logic                 pix_empty;
    logic                 pix_rd;
    logic [MB_DATA_W-1:0] pix_data;
    logic                 fifo_full;
    logic                 out_wr;
    logic [OUT_W-1:0]     out_data;
    logic                 done;

    logic [MB_DATA_W-1:0] pix_q [$];
    logic [OUT_W-1:0]     exp_q [$];
    logic [OUT_W-1:0]     exp_word;
    int                   errors;
    int                   timeouts;
    int                   cycles;
    int                   words_seen;
    int                   done_seen;
    int                   full_left;
    bit                   hold_off;

    mb_encode_top dut (
        .clk(clk), .rst_n(rst_n), .start(start), .mb_w(mb_w), .mb_h(mb_h),
        .q_shift(q_shift), .pix_empty(pix_empty), .pix_rd(pix_rd), .pix_data(pix_data),
        .fifo_full(fifo_full), .out_wr(out_wr), .out_data(out_data), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic finish_run;
        $display("Checks complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // --------------------
    // FIFO models
    // --------------------
    always @(posedge clk) begin
        if (pix_rd) begin
            pix_data <= pix_q.pop_front();
        end
        pix_empty <= (pix_q.size() == 0) || ($urandom_range(2) == 0);
        if (full_left != 0) begin
            full_left = full_left - 1;
            fifo_full <= 1'b1;
        end else if ($urandom_range(3) == 0) begin
            full_left = int'($urandom_range(12, 1));
            fifo_full <= 1'b1;
        end else begin
            fifo_full <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            timeouts = timeouts + 1;
            $display("Timeout: the frames did not finish within the cycle limit");
            finish_run();
        end
    end

    // --------------------
    // Output checks
    // --------------------
    always @(posedge clk) begin
        if (rst_n) begin
            // After a burst, no new read until the sink has room again
            if (hold_off) begin
                if (fifo_full) begin
                    assert (!pix_rd) else begin
                        errors = errors + 1;
                        $display("A pixel read happened while the output FIFO stayed full");
                    end
                end else begin
                    hold_off = 1'b0;
                end
            end
            if (done) begin
                done_seen = done_seen + 1;
                assert (exp_q.size() == 0) else begin
                    errors = errors + 1;
                    $display("done pulsed while output words of the frame were still due");
                end
            end
            if (out_wr) begin
                words_seen = words_seen + 1;
                if (words_seen % WORDS_PER_MB == 0) begin
                    hold_off = 1'b1;
                end
                if (exp_q.size() == 0) begin
                    errors = errors + 1;
                    $display("An output word was written with none expected");
                end else begin
                    exp_word = exp_q.pop_front();
                    assert (out_data === exp_word) else begin
                        errors = errors + 1;
                        $display("Error: out_data expected %h got %h", exp_word, out_data);
                    end
                end
            end
        end
    end

    // Builds input words and expected output for a frame, then runs it
    task automatic run_frame(input int w, input int h, input int q);
        logic [EDGE_W-1:0]    top_buf [MAX_MB_W];
        bit                   top_ok  [MAX_MB_W];
        logic [EDGE_W-1:0]    left_col;
        logic [EDGE_W-1:0]    top;
        logic [EDGE_W-1:0]    left;
        logic [MB_DATA_W-1:0] pix;
        logic [MB_DATA_W-1:0] lv;
        logic [MB_DATA_W-1:0] rc;
        logic [PIX_W-1:0]     pr;
        int                   sum;
        int                   lvl;
        int                   rec;
        int                   nzc;
        int                   words_before;
        int                   dones_before;
        @(negedge clk);
        words_before = words_seen;
        dones_before = done_seen;
        left_col = '0;
        for (int i = 0; i < MAX_MB_W; i++) begin
            top_ok[i] = 1'b0;
        end
        for (int yy = 0; yy < h; yy++) begin
            for (int xx = 0; xx < w; xx++) begin
                top = top_ok[xx] ? top_buf[xx] : {MB_SIDE{TOP_DEFAULT}};
                left = (xx == 0) ? {MB_SIDE{LEFT_DEFAULT}} : left_col;
                sum = 4;
                for (int i = 0; i < MB_SIDE; i++) begin
                    sum = sum + int'(top[i*PIX_W +: PIX_W]) + int'(left[i*PIX_W +: PIX_W]);
                end
                pr = PIX_W'(sum / 8);
                // Some blocks sit exactly on the DC value
                if ((yy * w + xx) % 3 == 2) begin
                    pix = {MB_PIX{pr}};
                end else begin
                    pix = {$urandom, $urandom, $urandom, $urandom};
                end
                nzc = 0;
                for (int i = 0; i < MB_PIX; i++) begin
                    lvl = (int'(pix[i*PIX_W +: PIX_W]) - int'(pr)) >>> q;
                    lvl = (lvl > 127) ? 127 : ((lvl < -128) ? -128 : lvl);
                    rec = int'(pr) + lvl * (1 << q);
                    rec = (rec > 255) ? 255 : ((rec < 0) ? 0 : rec);
                    lv[i*PIX_W +: PIX_W] = lvl[7:0];
                    rc[i*PIX_W +: PIX_W] = rec[7:0];
                    if (lvl != 0) begin
                        nzc = nzc + 1;
                    end
                end
                top_buf[xx] = rc[MB_DATA_W-1 -: EDGE_W];
                top_ok[xx] = 1'b1;
                left_col = {rc[127:120], rc[95:88], rc[63:56], rc[31:24]};
                pix_q.push_back(pix);
                exp_q.push_back({42'd0, pr, NZ_W'(nzc), (nzc == 0), COORD_W'(yy), COORD_W'(xx)});
                exp_q.push_back(lv[OUT_W-1:0]);
                exp_q.push_back(lv[MB_DATA_W-1:OUT_W]);
            end
        end
        @(posedge clk);
        start <= 1'b1;
        mb_w <= (COORD_W+1)'(w);
        mb_h <= (COORD_W+1)'(h);
        q_shift <= 3'(q);
        @(posedge clk);
        start <= 1'b0;
        do @(posedge clk); while (!done);
        @(negedge clk);
        assert (exp_q.size() == 0 && words_seen - words_before == WORDS_PER_MB * w * h) else begin
            errors = errors + 1;
            $display("Frame %0dx%0d finished with %0d words written", w, h,
                     words_seen - words_before);
        end
        assert (done_seen == dones_before + 1) else begin
            errors = errors + 1;
            $display("done did not pulse exactly once for frame %0dx%0d", w, h);
        end
    endtask

    initial begin
        void'($urandom(32'h658bb12e));
        rst_n     = 1'b0;
        start     = 1'b0;
        mb_w      = '0;
        mb_h      = '0;
        q_shift   = 3'd1;
        pix_empty = 1'b1;
        pix_data  = '0;
        fifo_full = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_frame(1, 1, 1);
        run_frame(4, 3, 3);
        run_frame(16, 2, 7);
        // Small frame again to see the edges restart from defaults
        run_frame(3, 2, 1);
        finish_run();
    end

endmodule
